/* verilog/fcvt_pkg.sv */
/*
 * Shared types and constants for the floating-point conversion unit.
 * Holds the IEEE-754 single layout, converter micro-op, flag and status
 * bundles, the AXI4-Lite request/response structs and the register map.
 */

package fcvt_pkg;

    // ======================================================================
    // Floating point and conversion types
    // ======================================================================

    // Exponent bias of an IEEE-754 single
    localparam logic [7:0] BIAS = 8'd127;

    // Packed single, also usable directly as a raw 32-bit word
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] significand;
    } float_t;

    typedef enum logic {
        FLOAT2INT = 1'b0,
        INT2FLOAT = 1'b1
    } conversion_type_t;

    typedef struct packed {
        conversion_type_t cvt_type;
        logic             is_signed;
    } fcvt_uop_t;

    typedef struct packed {
        logic guard;
        logic round;
        logic sticky;
    } round_bits_t;

    typedef struct packed {
        logic overflow;
        logic underflow;
        logic invalid;
        logic inexact;
    } fcvt_flags_t;

    // Sits in the low 6 bits of STATUS, busy on bit 5
    typedef struct packed {
        logic        busy;
        logic        done;
        fcvt_flags_t flags;
    } fcvt_status_t;

    // ======================================================================
    // AXI4-Lite bundles and register map
    // ======================================================================

    localparam int AXIL_ADDR_W = 4;

    localparam logic [AXIL_ADDR_W-1:0] REG_OPERAND = 4'h0;
    localparam logic [AXIL_ADDR_W-1:0] REG_CONTROL = 4'h4;
    localparam logic [AXIL_ADDR_W-1:0] REG_RESULT  = 4'h8;
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS  = 4'hC;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Everything the master drives
    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] awaddr;
        logic                   awvalid;
        logic [31:0]            wdata;
        logic [3:0]             wstrb;
        logic                   wvalid;
        logic                   bready;
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   arvalid;
        logic                   rready;
    } axil_req_t;

    // Everything the slave drives
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

endpackage : fcvt_pkg

/* verilog/count_leading_zeros.sv */
/*
 * Leading-zero counter built as a recursive halving tree.
 * WIDTH must be a power of two, at least 2. The count is meaningless
 * when is_all_zero_o is set.
 */

`timescale 1ns/1ps

module count_leading_zeros #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]         operand_i,
    output logic [$clog2(WIDTH)-1:0] lz_count_o,
    output logic                     is_all_zero_o
);

    generate
        if (WIDTH == 2) begin : g_leaf
            // Two bits: one leading zero unless the upper bit is set
            assign lz_count_o    = ~operand_i[1];
            assign is_all_zero_o = ~(|operand_i);
        end else begin : g_node
            logic [$clog2(WIDTH/2)-1:0] hi_count;
            logic [$clog2(WIDTH/2)-1:0] lo_count;
            logic                       hi_zero;
            logic                       lo_zero;

            count_leading_zeros #(.WIDTH(WIDTH/2)) i_clz_hi (
                .operand_i     (operand_i[WIDTH-1:WIDTH/2]),
                .lz_count_o    (hi_count),
                .is_all_zero_o (hi_zero)
            );

            count_leading_zeros #(.WIDTH(WIDTH/2)) i_clz_lo (
                .operand_i     (operand_i[WIDTH/2-1:0]),
                .lz_count_o    (lo_count),
                .is_all_zero_o (lo_zero)
            );

            // An empty upper half adds its full width, which is the new MSB
            assign lz_count_o    = hi_zero ? {1'b1, lo_count} : {1'b0, hi_count};
            assign is_all_zero_o = hi_zero & lo_zero;
        end
    endgenerate

endmodule : count_leading_zeros

/* verilog/float_converter.sv */
/*
 * Two-stage float/integer converter. Stage 0 registers the pre-shifted
 * operand, stage 1 is combinational and produces the raw result, the
 * round bits for the rounder and the exception flags.
 */

`timescale 1ns/1ps

module float_converter
    import fcvt_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        valid_i,
    input  float_t      operand_i,
    input  fcvt_uop_t   operation_i,
    input  logic        is_nan_i,
    output float_t      result_o,
    output logic        valid_o,
    output round_bits_t round_bits_o,
    output logic        overflow_o,
    output logic        underflow_o,
    output logic        invalid_o
);

    // ======================================================================
    // Float to integer
    // ======================================================================

    logic        hidden_bit;
    logic [4:0]  f2i_shift;
    logic [54:0] f2i_shifted;

    // Denormals never reach the integer range, so the hidden bit is enough
    assign hidden_bit = operand_i.exponent != '0;
    assign f2i_shift  = 5'(operand_i.exponent - BIAS);

    // Integer part lands in bits 54:23, fraction bits fall below
    assign f2i_shifted = {31'b0, hidden_bit, operand_i.significand} << f2i_shift;

    logic [31:0] f2i_int_stg0;
    logic        below_one_stg0;
    logic        ge_2p31_stg0;
    logic        ge_2p32_stg0;
    logic        sign_stg0;
    logic        is_nan_stg0;
    fcvt_uop_t   uop_stg0;

    always_ff @(posedge clk_i) begin
        f2i_int_stg0   <= f2i_shifted[54:23];
        below_one_stg0 <= operand_i.exponent < BIAS;
        ge_2p31_stg0   <= operand_i.exponent >= BIAS + 8'd31;
        ge_2p32_stg0   <= operand_i.exponent >= BIAS + 8'd32;
        sign_stg0      <= operand_i.sign;
        is_nan_stg0    <= is_nan_i;
        uop_stg0       <= operation_i;
    end

    logic [31:0] f2i_value;
    logic        f2i_overflow;
    logic        f2i_underflow;

    always_comb begin
        f2i_value     = f2i_int_stg0;
        f2i_overflow  = 1'b0;
        f2i_underflow = 1'b0;

        if (below_one_stg0) begin
            // Magnitude below one truncates to zero
            f2i_value = '0;
        end else if (uop_stg0.is_signed) begin
            if (ge_2p31_stg0) begin
                // Outside the signed range, clamp to the nearest limit
                if (sign_stg0) begin
                    f2i_value     = 32'h8000_0000;
                    f2i_underflow = 1'b1;
                end else begin
                    f2i_value    = 32'h7FFF_FFFF;
                    f2i_overflow = 1'b1;
                end
            end else if (sign_stg0) begin
                f2i_value = -f2i_int_stg0;
            end
        end else begin
            if (sign_stg0) begin
                // No negative unsigned values exist
                f2i_value     = '0;
                f2i_underflow = 1'b1;
            end else if (ge_2p32_stg0) begin
                f2i_value    = '1;
                f2i_overflow = 1'b1;
            end
        end
    end

    // ======================================================================
    // Integer to float
    // ======================================================================

    logic [31:0] i2f_magnitude;
    logic [4:0]  i2f_clz;
    logic        i2f_all_zero;

    // Negating the most negative value still gives the right magnitude
    assign i2f_magnitude = (operation_i.is_signed & operand_i[31]) ? -operand_i : operand_i;

    count_leading_zeros #(.WIDTH(32)) i_clz (
        .operand_i     (i2f_magnitude),
        .lz_count_o    (i2f_clz),
        .is_all_zero_o (i2f_all_zero)
    );

    logic [31:0] i2f_magnitude_stg0;
    logic [4:0]  i2f_clz_stg0;
    logic        i2f_all_zero_stg0;
    logic        i2f_sign_stg0;

    always_ff @(posedge clk_i) begin
        i2f_magnitude_stg0 <= i2f_magnitude;
        i2f_clz_stg0       <= i2f_clz;
        i2f_all_zero_stg0  <= i2f_all_zero;
        i2f_sign_stg0      <= operation_i.is_signed & operand_i[31];
    end

    logic [31:0] i2f_normalized;
    logic [7:0]  i2f_exponent;
    float_t      i2f_value;
    round_bits_t i2f_round_bits;

    // After normalization the leading one sits in bit 31 and is dropped
    assign i2f_normalized = i2f_magnitude_stg0 << i2f_clz_stg0;
    assign i2f_exponent   = i2f_all_zero_stg0 ? '0 :
                            BIAS + (8'd31 - {3'b0, i2f_clz_stg0});

    assign i2f_value.sign        = i2f_sign_stg0;
    assign i2f_value.exponent    = i2f_exponent;
    assign i2f_value.significand = i2f_normalized[30:8];

    // Guard and round are the next two bits, sticky ORs the rest
    assign i2f_round_bits.guard  = i2f_normalized[7];
    assign i2f_round_bits.round  = i2f_normalized[6];
    assign i2f_round_bits.sticky = |i2f_normalized[5:0];

    // ======================================================================
    // Output stage
    // ======================================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_comb begin
        if (uop_stg0.cvt_type == INT2FLOAT) begin
            result_o     = i2f_value;
            round_bits_o = i2f_round_bits;
            overflow_o   = 1'b0;
            underflow_o  = 1'b0;
            invalid_o    = 1'b0;
        end else begin
            // Integer results are exact after truncation, no rounding
            result_o     = f2i_value;
            round_bits_o = '0;
            overflow_o   = f2i_overflow;
            underflow_o  = f2i_underflow;
            invalid_o    = is_nan_stg0;
        end
    end

endmodule : float_converter

/* verilog/float_rounder.sv */
/*
 * Registered round-to-nearest-even stage behind the converter.
 * Adjusts significand and exponent from the round bits and collects
 * all exception flags, including inexact. Adds one cycle of latency.
 */

`timescale 1ns/1ps

module float_rounder
    import fcvt_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        valid_i,
    input  float_t      result_i,
    input  round_bits_t round_bits_i,
    input  logic        overflow_i,
    input  logic        underflow_i,
    input  logic        invalid_i,
    output float_t      result_o,
    output fcvt_flags_t flags_o,
    output logic        valid_o
);

    logic        round_up;
    logic [23:0] significand_sum;
    float_t      rounded;

    // Above halfway, or exactly halfway with an odd significand
    assign round_up = round_bits_i.guard &
                      (round_bits_i.round | round_bits_i.sticky | result_i.significand[0]);

    assign significand_sum = {1'b0, result_i.significand} + 24'(round_up);

    always_comb begin
        rounded             = result_i;
        rounded.significand = significand_sum[22:0];
        // A carry out means 1.111.. became 10.000.., bump the exponent
        if (significand_sum[23]) begin
            rounded.exponent = result_i.exponent + 8'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Float-to-integer words have zero round bits and pass unchanged
    always_ff @(posedge clk_i) begin
        result_o          <= rounded;
        flags_o.overflow  <= overflow_i;
        flags_o.underflow <= underflow_i;
        flags_o.invalid   <= invalid_i;
        flags_o.inexact   <= |round_bits_i;
    end

endmodule : float_rounder

/* verilog/fcvt_ctrl.sv */
/*
 * AXI4-Lite slave and register bank of the conversion unit.
 * A CONTROL write starts one conversion, the result and flags are
 * captured when the rounder returns valid. Host polls STATUS.
 */

`timescale 1ns/1ps

module fcvt_ctrl
    import fcvt_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  axil_req_t   axil_req_i,
    output axil_rsp_t   axil_rsp_o,
    output float_t      operand_o,
    output fcvt_uop_t   operation_o,
    output logic        is_nan_o,
    output logic        start_o,
    input  float_t      result_i,
    input  fcvt_flags_t flags_i,
    input  logic        result_valid_i
);

    logic         awready_q;
    logic         bvalid_q;
    logic [1:0]   bresp_q;
    logic         rvalid_q;
    logic [1:0]   rresp_q;
    logic [31:0]  rdata_q;
    float_t       operand_q;
    fcvt_uop_t    uop_q;
    float_t       result_q;
    fcvt_flags_t  flags_q;
    logic         busy_q;
    logic         done_q;
    logic         start_q;
    fcvt_status_t status;

    // ======================================================================
    // Write channel
    // ======================================================================

    logic wr_fire;
    logic wr_is_operand;
    logic wr_is_control;
    logic start_accept;

    // AW and W are taken together, so one ready serves both channels
    assign wr_fire       = awready_q & axil_req_i.awvalid & axil_req_i.wvalid;
    assign wr_is_operand = axil_req_i.awaddr == REG_OPERAND;
    assign wr_is_control = axil_req_i.awaddr == REG_CONTROL;
    assign start_accept  = wr_fire & wr_is_control & ~busy_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            awready_q <= 1'b0;
            bvalid_q  <= 1'b0;
        end else begin
            // One-cycle ready pulse, held off while a B response waits
            awready_q <= axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q & ~awready_q;
            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (axil_req_i.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            // CONTROL while busy and every other address are refused
            bresp_q <= (wr_is_operand | start_accept) ? RESP_OKAY : RESP_SLVERR;
        end
        for (int b = 0; b < 4; b++) begin
            if (wr_fire & wr_is_operand & axil_req_i.wstrb[b]) begin
                operand_q[8*b +: 8] <= axil_req_i.wdata[8*b +: 8];
            end
        end
        if (start_accept) begin
            uop_q.cvt_type  <= conversion_type_t'(axil_req_i.wdata[0]);
            uop_q.is_signed <= axil_req_i.wdata[1];
        end
        if (result_valid_i) begin
            result_q <= result_i;
        end
    end

    // ======================================================================
    // Conversion sequencing
    // ======================================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            start_q <= 1'b0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            flags_q <= '0;
        end else begin
            start_q <= start_accept;
            if (start_accept) begin
                // Old done and flags stay visible until this point
                busy_q  <= 1'b1;
                done_q  <= 1'b0;
                flags_q <= '0;
            end else if (result_valid_i) begin
                busy_q  <= 1'b0;
                done_q  <= 1'b1;
                flags_q <= flags_i;
            end
        end
    end

    assign status.busy  = busy_q;
    assign status.done  = done_q;
    assign status.flags = flags_q;

    // NaN only matters when the operand is read as a float
    assign is_nan_o    = (operand_q.exponent == 8'hFF) & (operand_q.significand != '0) &
                         (uop_q.cvt_type == FLOAT2INT);
    assign operand_o   = operand_q;
    assign operation_o = uop_q;
    assign start_o     = start_q;

    // ======================================================================
    // Read channel
    // ======================================================================

    logic        rd_fire;
    logic [31:0] rd_data;
    logic [1:0]  rd_resp;

    assign rd_fire = axil_req_i.arvalid & ~rvalid_q;

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (axil_req_i.araddr)
            REG_OPERAND: rd_data = operand_q;
            REG_CONTROL: rd_data = {30'b0, uop_q.is_signed, uop_q.cvt_type};
            REG_RESULT:  rd_data = result_q;
            REG_STATUS:  rd_data = {26'b0, status};
            default:     rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
        end else if (axil_req_i.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_fire) begin
            rdata_q <= rd_data;
            rresp_q <= rd_resp;
        end
    end

    assign axil_rsp_o.awready = awready_q;
    assign axil_rsp_o.wready  = awready_q;
    assign axil_rsp_o.bresp   = bresp_q;
    assign axil_rsp_o.bvalid  = bvalid_q;
    assign axil_rsp_o.arready = ~rvalid_q;
    assign axil_rsp_o.rdata   = rdata_q;
    assign axil_rsp_o.rresp   = rresp_q;
    assign axil_rsp_o.rvalid  = rvalid_q;

endmodule : fcvt_ctrl

/* verilog/fcvt_top.sv */
/*
 * Top level of the conversion unit. Connects the AXI4-Lite register
 * block to the converter and the rounder, which form a 3-cycle path.
 */

`timescale 1ns/1ps

module fcvt_top
    import fcvt_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  axil_req_t axil_req_i,
    output axil_rsp_t axil_rsp_o
);

    // Control to converter
    float_t      cvt_operand;
    fcvt_uop_t   cvt_operation;
    logic        cvt_is_nan;
    logic        cvt_start;

    // Converter to rounder
    float_t      raw_result;
    round_bits_t raw_round_bits;
    logic        raw_overflow;
    logic        raw_underflow;
    logic        raw_invalid;
    logic        raw_valid;

    // Rounder back to control
    float_t      final_result;
    fcvt_flags_t final_flags;
    logic        final_valid;

    fcvt_ctrl i_fcvt_ctrl (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .axil_req_i     (axil_req_i),
        .axil_rsp_o     (axil_rsp_o),
        .operand_o      (cvt_operand),
        .operation_o    (cvt_operation),
        .is_nan_o       (cvt_is_nan),
        .start_o        (cvt_start),
        .result_i       (final_result),
        .flags_i        (final_flags),
        .result_valid_i (final_valid)
    );

    float_converter i_float_converter (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .valid_i      (cvt_start),
        .operand_i    (cvt_operand),
        .operation_i  (cvt_operation),
        .is_nan_i     (cvt_is_nan),
        .result_o     (raw_result),
        .valid_o      (raw_valid),
        .round_bits_o (raw_round_bits),
        .overflow_o   (raw_overflow),
        .underflow_o  (raw_underflow),
        .invalid_o    (raw_invalid)
    );

    float_rounder i_float_rounder (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .valid_i      (raw_valid),
        .result_i     (raw_result),
        .round_bits_i (raw_round_bits),
        .overflow_i   (raw_overflow),
        .underflow_i  (raw_underflow),
        .invalid_i    (raw_invalid),
        .result_o     (final_result),
        .flags_o      (final_flags),
        .valid_o      (final_valid)
    );

endmodule : fcvt_top

/* tests/fcvt_properties.sv */
/*
 * Concurrent checks on the AXI4-Lite responses and the status bits of
 * the register block. Bound into fcvt_ctrl from this file.
 */

`timescale 1ns/1ps

module fcvt_properties
    import fcvt_pkg::*;
(
    input logic      clk_i,
    input logic      rst_n_i,
    input axil_req_t axil_req_i,
    input axil_rsp_t axil_rsp_i,
    input logic      busy_i,
    input logic      done_i
);

    // A B response waits with the same code until the master takes it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        axil_rsp_i.bvalid && !axil_req_i.bready |=>
            axil_rsp_i.bvalid && $stable(axil_rsp_i.bresp))
        else $error("bvalid dropped or bresp changed before bready");

    // Same rule for read data
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        axil_rsp_i.rvalid && !axil_req_i.rready |=>
            axil_rsp_i.rvalid && $stable(axil_rsp_i.rdata) && $stable(axil_rsp_i.rresp))
        else $error("rvalid dropped or read payload changed before rready");

    // Done rises with busy clear exactly three cycles after busy rose
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(done_i) |-> !busy_i && $past(busy_i, 3) && !$past(busy_i, 4))
        else $error("done did not follow the start of a conversion by three cycles");

    // First edge out of reset still sees the reset values
    assert property (@(posedge clk_i) $rose(rst_n_i) |-> !axil_rsp_i.bvalid && !axil_rsp_i.rvalid)
        else $error("response valid high right after reset");

endmodule : fcvt_properties

bind fcvt_ctrl fcvt_properties i_fcvt_properties (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .axil_req_i (axil_req_i),
    .axil_rsp_i (axil_rsp_o),
    .busy_i     (busy_q),
    .done_i     (done_q)
);

/* tests/fcvt_tb.sv */
/*
 * Testbench for the conversion unit. Runs every conversion listed in
 * tests/fcvt_input.txt over AXI4-Lite, then checks the register protocol
 * with random bready/rready back-pressure. Run from the project root.
 */

`timescale 1ns/1ps

module fcvt_tb
    import fcvt_pkg::*;
;

    typedef struct packed {
        logic        op;
        logic        sgn;
        float_t      operand;
        float_t      expected;
        fcvt_flags_t flags;
    } vector_t;

    logic      clk;
    logic      rst_n;
    axil_req_t req;
    axil_rsp_t rsp;

    int        mismatch_count;
    int        other_count;
    int        cycle_count;
    int        cycle_limit;
    logic      fast_resp;
    vector_t   vectors[$];

    fcvt_top i_fcvt_top (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .axil_req_i (req),
        .axil_rsp_o (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ======================================================================
    // Timeout and compare tasks
    // ======================================================================

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Error: run timed out after %0d cycles", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_result(input float_t act, input float_t exp, input string msg);
        if (act !== exp) begin
            mismatch_count++;
            $display("Fail at %0t: %s result %h, expected %h", $time, msg, act, exp);
        end
    endtask

    task automatic check_flags(input fcvt_flags_t act, input fcvt_flags_t exp,
                               input string msg);
        if (act !== exp) begin
            mismatch_count++;
            $display("Fail at %0t: %s flags %b, expected %b", $time, msg, act, exp);
        end
    endtask

    task automatic check_resp(input logic [1:0] act, input logic [1:0] exp, input string msg);
        if (act !== exp) begin
            mismatch_count++;
            $display("Fail at %0t: %s response %b, expected %b", $time, msg, act, exp);
        end
    endtask

    // ======================================================================
    // AXI4-Lite master tasks
    // ======================================================================

    // Signals are driven 1 ns after a rising edge and sampled at falling edges
    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        int unsigned delay;
        delay = fast_resp ? 0 : $urandom_range(3, 0);
        req.awaddr  = addr;
        req.awvalid = 1'b1;
        req.wdata   = data;
        req.wstrb   = strb;
        req.wvalid  = 1'b1;
        // With no delay bready is already up when bvalid arrives
        req.bready  = (delay == 0);
        do @(negedge clk); while (!(rsp.awready && rsp.wready));
        @(posedge clk);
        #1;
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        while (!rsp.bvalid) @(negedge clk);
        if (delay > 0) begin
            repeat (delay) @(posedge clk);
            #1;
            req.bready = 1'b1;
            @(negedge clk);
        end
        resp = rsp.bresp;
        @(posedge clk);
        #1;
        req.bready = 1'b0;
        if (rsp.bvalid) begin
            other_count++;
            $display("Error: write response still pending after it was accepted");
        end
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int unsigned delay;
        delay = fast_resp ? 0 : $urandom_range(3, 0);
        req.araddr  = addr;
        req.arvalid = 1'b1;
        req.rready  = (delay == 0);
        do @(negedge clk); while (!rsp.arready);
        @(posedge clk);
        #1;
        req.arvalid = 1'b0;
        while (!rsp.rvalid) @(negedge clk);
        if (delay > 0) begin
            repeat (delay) @(posedge clk);
            #1;
            req.rready = 1'b1;
            @(negedge clk);
        end
        data = rsp.rdata;
        resp = rsp.rresp;
        @(posedge clk);
        #1;
        req.rready = 1'b0;
        if (rsp.rvalid) begin
            other_count++;
            $display("Error: read response still pending after it was accepted");
        end
    endtask

    // Polls STATUS until done, the flags come back with it
    task automatic wait_done(output fcvt_status_t st);
        logic [31:0] data;
        logic [1:0]  resp;
        do begin
            axil_read(REG_STATUS, data, resp);
            check_resp(resp, RESP_OKAY, "status read");
            st = fcvt_status_t'(data[5:0]);
        end while (!st.done);
        if (st.busy) begin
            other_count++;
            $display("Error: busy still set while done is reported");
        end
    endtask

    task automatic read_inputs();
        int          fd;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_sgn;
        logic [31:0] f_operand;
        logic [31:0] f_exp;
        logic [31:0] f_flags;
        vector_t     v;
        fd = $fopen("tests/fcvt_input.txt", "r");
        if (fd == 0) begin
            other_count++;
            $display("Error: cannot open tests/fcvt_input.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if ($sscanf(line, "%h %h %h %h %h", f_op, f_sgn, f_operand, f_exp, f_flags) == 5) begin
                v.op       = f_op[0];
                v.sgn      = f_sgn[0];
                v.operand  = f_operand;
                v.expected = f_exp;
                v.flags    = f_flags[3:0];
                vectors.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin : main
        logic [31:0]  data;
        logic [1:0]   resp;
        fcvt_status_t st;
        string        tag;

        mismatch_count = 0;
        other_count    = 0;
        cycle_count    = 0;
        cycle_limit    = 100000;
        fast_resp      = 1'b0;
        rst_n          = 1'b0;
        req            = '0;
        void'($urandom(32'h4e26_208d));

        read_inputs();
        cycle_limit = 60 * vectors.size() + 200;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        foreach (vectors[i]) begin
            tag = $sformatf("line %0d operand %h", i, vectors[i].operand);
            axil_write(REG_OPERAND, vectors[i].operand, 4'hF, resp);
            check_resp(resp, RESP_OKAY, "operand write");
            axil_write(REG_CONTROL, {30'b0, vectors[i].sgn, vectors[i].op}, 4'hF, resp);
            check_resp(resp, RESP_OKAY, "control write");
            wait_done(st);
            axil_read(REG_RESULT, data, resp);
            check_result(data, vectors[i].expected, tag);
            check_flags(st.flags, vectors[i].flags, tag);
            // Result stays put until the next start
            axil_read(REG_RESULT, data, resp);
            check_result(data, vectors[i].expected, {tag, " reread"});
        end

        // Byte strobes on OPERAND
        axil_write(REG_OPERAND, 32'h1122_3344, 4'hF, resp);
        axil_write(REG_OPERAND, 32'hAABB_CCDD, 4'b0101, resp);
        axil_read(REG_OPERAND, data, resp);
        check_result(data, 32'h11BB_33DD, "strobed operand");

        // Refused writes leave everything untouched
        axil_write(REG_RESULT, 32'hDEAD_BEEF, 4'hF, resp);
        check_resp(resp, RESP_SLVERR, "result write");
        axil_write(REG_STATUS, 32'hFFFF_FFFF, 4'hF, resp);
        check_resp(resp, RESP_SLVERR, "status write");
        axil_write(4'h2, 32'h0000_0000, 4'hF, resp);
        check_resp(resp, RESP_SLVERR, "unmapped write");
        axil_read(REG_RESULT, data, resp);
        check_result(data, vectors[vectors.size()-1].expected, "result after refused writes");
        axil_read(REG_OPERAND, data, resp);
        check_result(data, 32'h11BB_33DD, "operand after refused writes");
        axil_read(4'h2, data, resp);
        check_resp(resp, RESP_SLVERR, "unmapped read");
        check_result(data, 32'h0, "unmapped read data");

        // Second CONTROL write lands while the first conversion is in flight
        axil_write(REG_OPERAND, 32'h3F80_0000, 4'hF, resp);
        fast_resp = 1'b1;
        axil_write(REG_CONTROL, 32'h2, 4'hF, resp);
        check_resp(resp, RESP_OKAY, "first control write");
        axil_write(REG_CONTROL, 32'h1, 4'hF, resp);
        check_resp(resp, RESP_SLVERR, "control write while busy");
        fast_resp = 1'b0;
        wait_done(st);
        axil_read(REG_RESULT, data, resp);
        check_result(data, 32'h0000_0001, "conversion after refused start");
        check_flags(st.flags, '0, "conversion after refused start");
        axil_read(REG_CONTROL, data, resp);
        check_result(data, 32'h2, "control after refused start");

        $display("Errors: %0d value mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : fcvt_tb

/* files.f */
verilog/fcvt_pkg.sv
verilog/count_leading_zeros.sv
verilog/float_converter.sv
verilog/float_rounder.sv
verilog/fcvt_ctrl.sv
verilog/fcvt_top.sv
tests/fcvt_properties.sv
tests/fcvt_tb.sv

/* run.sh */
#!/bin/sh
# Builds the conversion unit testbench with Verilator and runs it.
# Exit status is zero only when the testbench reports a pass.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f files.f \
    --top-module fcvt_tb \
    -o fcvt_sim

out=$(./obj_dir/fcvt_sim) || true
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
else
    exit 1
fi

/* tests/fcvt_input.txt */
# op (1 int2float, 0 float2int)  signed  operand  expected  flags {ovf,unf,inv,inx}
# all fields hex
1 1 00000000 00000000 0
1 1 00000001 3F800000 0
1 1 FFFFFFFF BF800000 0
1 1 80000000 CF000000 0
1 0 80000000 4F000000 0
1 0 FFFFFFFF 4F800000 1
1 1 00000400 44800000 0
1 0 01000001 4B800000 1
1 0 01000003 4B800002 1
1 0 01000002 4B800001 0
1 1 FEFFFFFF CB800000 1
1 0 00FFFFFF 4B7FFFFF 0
1 1 7FFFFFFF 4F000000 1
0 1 3F800000 00000001 0
0 1 C0200000 FFFFFFFE 0
0 1 3F000000 00000000 0
0 1 BF7FFFFF 00000000 0
0 1 42F6E979 0000007B 0
0 1 C2F60000 FFFFFF85 0
0 0 4B7FFFFF 00FFFFFF 0
0 0 4F000000 80000000 0
0 1 4F000000 7FFFFFFF 8
0 1 CF000000 80000000 4
0 1 D0000000 80000000 4
0 0 C0000000 00000000 4
0 0 4F800000 FFFFFFFF 8
0 1 7FC00000 7FFFFFFF A
